// ==== src/sm83Pkg.sv ====
`default_nettype none

package sm83Pkg;

  localparam int addrWidth = 16;
  localparam int dataWidth = 8;

  localparam logic [addrWidth-1:0] ioPageBase = 16'hFF00; // High I/O page

  // Same encoding as the opcode register field where 6 is [HL]
  typedef enum logic [2:0] {
    regB = 3'd0,
    regC = 3'd1,
    regD = 3'd2,
    regE = 3'd3,
    regH = 3'd4,
    regL = 3'd5,
    regA = 3'd7
  } regSel_t;

  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluAdc = 4'd1,
    aluSub = 4'd2,
    aluSbc = 4'd3,
    aluAnd = 4'd4,
    aluXor = 4'd5,
    aluOr  = 4'd6,
    aluCp  = 4'd7,
    aluInc = 4'd8
  } aluOp_t;

  typedef enum logic [2:0] {
    stFetch  = 3'd0,
    stDecode = 3'd1,
    stExec0  = 3'd2,
    stExec1  = 3'd3,
    stExec2  = 3'd4,
    stTrap   = 3'd5
  } seqState_t;

  localparam int flagZero  = 3;
  localparam int flagSub   = 2;
  localparam int flagHalf  = 1;
  localparam int flagCarry = 0;

endpackage

`default_nettype wire

// ==== src/cpuBusIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cpuBusIf import sm83Pkg::*; ();

  logic                 req;
  logic                 we;
  logic [addrWidth-1:0] adr;
  logic [dataWidth-1:0] datW;
  logic [dataWidth-1:0] datR;
  logic                 done; // One-cycle pulse with datR valid

  modport controller (output req, we, adr, datW, input datR, done);
  modport worker (input req, we, adr, datW, output datR, done);

endinterface

`default_nettype wire

// ==== src/writebackIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface writebackIf import sm83Pkg::*; ();

  logic                 regWe;
  regSel_t              dst;
  logic [dataWidth-1:0] data;
  logic                 flagWe;
  logic [3:0]           flags;
  regSel_t              rdSel;
  logic [dataWidth-1:0] rdData;
  logic [dataWidth-1:0] aData;
  logic [3:0]           fData;

  modport controller (
    output regWe, dst, data, flagWe, flags, rdSel,
    input  rdData, aData, fData
  );
  modport worker (
    input  regWe, dst, data, flagWe, flags, rdSel,
    output rdData, aData, fData
  );

endinterface

`default_nettype wire

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit import sm83Pkg::*; (
  input  aluOp_t               op,
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  logic [3:0]           flagsIn,
  output logic [dataWidth-1:0] res,
  output logic [3:0]           flagsOut
);

  logic       cin;
  logic [8:0] addFull, subFull;
  logic [4:0] addHalf, subHalf;
  logic       n, h, c;

  assign cin = ((op == aluAdc) || (op == aluSbc)) && flagsIn[flagCarry];

  assign addFull = {1'b0, a} + {1'b0, b} + {8'h00, cin};
  assign addHalf = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'h0, cin};
  assign subFull = {1'b0, a} - {1'b0, b} - {8'h00, cin}; // Bit 8 is the borrow
  assign subHalf = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'h0, cin};

  always_comb
  begin
    res = addFull[7:0];
    n   = 1'b0;
    h   = addHalf[4];
    c   = addFull[8];
    case (op)
      aluSub, aluSbc, aluCp:
      begin
        res = subFull[7:0];
        n   = 1'b1;
        h   = subHalf[4];
        c   = subFull[8];
      end
      aluAnd:
      begin
        res = a & b;
        h   = 1'b1;
        c   = 1'b0;
      end
      aluXor:
      begin
        res = a ^ b;
        h   = 1'b0;
        c   = 1'b0;
      end
      aluOr:
      begin
        res = a | b;
        h   = 1'b0;
        c   = 1'b0;
      end
      aluInc:
      begin
        res = b + 8'h01;
        h   = (b[3:0] == 4'hF);
        c   = flagsIn[flagCarry]; // Carry untouched
      end
      default:
      begin
      end
    endcase
    flagsOut            = 4'h0;
    flagsOut[flagZero]  = (res == 8'h00);
    flagsOut[flagSub]   = n;
    flagsOut[flagHalf]  = h;
    flagsOut[flagCarry] = c;
  end

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile import sm83Pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  writebackIf.worker           wb,
  output logic [dataWidth-1:0] aData
);

  logic [dataWidth-1:0] bank [0:5]; // B, C, D, E, H, L
  logic [dataWidth-1:0] regAcc;
  logic [3:0]           regF;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 6; i++)
        bank[i] <= '0;
      regAcc <= '0;
      regF   <= '0;
    end
    else
    begin
      if (wb.regWe)
      begin
        if (wb.dst == regA)
          regAcc <= wb.data;
        else
          bank[wb.dst] <= wb.data;
      end
      if (wb.flagWe)
        regF <= wb.flags;
    end
  end

  assign wb.rdData = (wb.rdSel == regA) ? regAcc : bank[wb.rdSel];
  assign wb.aData  = regAcc;
  assign wb.fData  = regF;
  assign aData     = regAcc;

endmodule

`default_nettype wire

// ==== src/wbMaster.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbMaster import sm83Pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  cpuBusIf.worker              bus,
  output logic [addrWidth-1:0] wbAdr,
  output logic [dataWidth-1:0] wbDatO,
  input  logic [dataWidth-1:0] wbDatI,
  output logic                 wbWe,
  output logic                 wbCyc,
  output logic                 wbStb,
  input  logic                 wbAck
);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wbCyc    <= 1'b0;
      wbStb    <= 1'b0;
      wbWe     <= 1'b0;
      bus.done <= 1'b0;
    end
    else
    begin
      bus.done <= 1'b0;
      if (wbCyc)
      begin
        if (wbAck)
        begin
          wbCyc    <= 1'b0;
          wbStb    <= 1'b0;
          wbWe     <= 1'b0;
          bus.datR <= wbDatI;
          bus.done <= 1'b1;
        end
      end
      else if (bus.req && !bus.done) // req still high while done shows
      begin
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= bus.we;
        wbAdr  <= bus.adr;
        wbDatO <= bus.datW;
      end
    end
  end

  stbInCyc: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc);

  adrHeld: assert property (@(posedge clk) disable iff (reset)
    (wbStb && !wbAck) |=> $stable(wbAdr));

endmodule

`default_nettype wire

// ==== src/instrSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrSequencer import sm83Pkg::*; #(
  parameter logic [addrWidth-1:0] resetVector = '0,
  parameter logic [addrWidth-1:0] ioBase      = ioPageBase
) (
  input  logic                 clk,
  input  logic                 reset,
  cpuBusIf.controller          bus,
  writebackIf.controller       wb,
  output aluOp_t               aluOp,
  output logic [dataWidth-1:0] aluB,
  input  logic [dataWidth-1:0] aluRes,
  input  logic [3:0]           aluFlags,
  output logic                 trap
);

  seqState_t            state;
  logic [addrWidth-1:0] pc;
  logic [dataWidth-1:0] ir;
  logic [dataWidth-1:0] imm;

  logic [1:0] insX;
  logic [2:0] insY;
  logic [2:0] insZ;
  logic       isNop, isLdImm, isInc, isJrCc, isAlu, isLdh;
  logic       ldhStore, jrTaken, busPhase;

  assign insX = ir[7:6];
  assign insY = ir[5:3];
  assign insZ = ir[2:0];

  assign isNop   = (ir == 8'h00);
  assign isLdImm = (insX == 2'd0) && (insZ == 3'd6) && (insY != 3'd6);
  assign isInc   = (insX == 2'd0) && (insZ == 3'd4) && (insY != 3'd6);
  assign isJrCc  = (insX == 2'd0) && (insZ == 3'd0) && insY[2];
  assign isAlu   = (insX == 2'd2) && (insZ != 3'd6);
  assign isLdh   = (insX == 2'd3) && (insZ == 3'd0) && (insY == 3'd4 || insY == 3'd6);
  assign ldhStore = (insY == 3'd4); // E0 stores and F0 loads

  // Condition code in Y[1:0] picks NZ, Z, NC or C
  assign jrTaken = insY[1] ? (wb.fData[flagCarry] == insY[0])
                           : (wb.fData[flagZero] == insY[0]);

  assign busPhase = (state == stFetch) || (state == stExec2) ||
                    ((state == stExec0) && !(isInc || isAlu));

  assign aluOp = isInc ? aluInc : aluOp_t'({1'b0, insY});
  assign aluB  = wb.rdData;
  assign wb.rdSel = isInc ? regSel_t'(insY) : regSel_t'(insZ);

  assign wb.regWe = ((state == stExec0) && (isInc || (isAlu && insY != 3'd7))) ||
                    ((state == stExec0) && isLdImm && bus.done) ||
                    ((state == stExec2) && isLdh && !ldhStore && bus.done);
  assign wb.dst    = (isInc || isLdImm) ? regSel_t'(insY) : regA;
  assign wb.data   = (isInc || isAlu) ? aluRes : bus.datR;
  assign wb.flagWe = (state == stExec0) && (isInc || isAlu);
  assign wb.flags  = aluFlags;

  assign trap = (state == stTrap);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state   <= stFetch;
      pc      <= resetVector;
      ir      <= 8'h00;
      bus.req <= 1'b0;
      bus.we  <= 1'b0;
    end
    else
    begin
      if (bus.done)
        bus.req <= 1'b0; // Drop in the cycle after done
      else if (!bus.req && busPhase)
      begin
        bus.req  <= 1'b1;
        bus.adr  <= (state == stExec2) ? ioBase + {8'h00, imm} : pc;
        bus.we   <= (state == stExec2) && ldhStore;
        bus.datW <= wb.aData;
      end

      case (state)
        stFetch:
          if (bus.done)
          begin
            ir    <= bus.datR;
            pc    <= pc + 1'b1;
            state <= stDecode;
          end
        stDecode:
          if (isNop)
            state <= stFetch;
          else if (isLdImm || isInc || isJrCc || isAlu || isLdh)
            state <= stExec0;
          else
            state <= stTrap;
        stExec0:
          if (isInc || isAlu)
            state <= stFetch; // Written back this cycle
          else if (bus.done)
          begin
            imm   <= bus.datR;
            pc    <= pc + 1'b1;
            state <= isJrCc ? stExec1 : (isLdh ? stExec2 : stFetch);
          end
        stExec1:
        begin
          if (jrTaken)
            pc <= pc + {{(addrWidth - dataWidth){imm[7]}}, imm};
          state <= stFetch;
        end
        stExec2:
          if (bus.done)
            state <= stFetch;
        default:
          state <= stTrap; // Held until reset
      endcase
    end
  end

  stateLegal: assert property (@(posedge clk) disable iff (reset)
    state inside {stFetch, stDecode, stExec0, stExec1, stExec2, stTrap});

  noReqOnDone: assert property (@(posedge clk) disable iff (reset)
    $rose(bus.req) |-> !bus.done);

endmodule

`default_nettype wire

// ==== src/sm83Core.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm83Core import sm83Pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  output logic [addrWidth-1:0] wbAdr,
  output logic [dataWidth-1:0] wbDatO,
  input  logic [dataWidth-1:0] wbDatI,
  output logic                 wbWe,
  output logic                 wbCyc,
  output logic                 wbStb,
  input  logic                 wbAck,
  output logic                 trap
);

  localparam logic [addrWidth-1:0] resetVector = '0;
  localparam logic [addrWidth-1:0] ioBase      = ioPageBase;

  aluOp_t               aluOp;
  logic [dataWidth-1:0] aluA;
  logic [dataWidth-1:0] aluB;
  logic [dataWidth-1:0] aluRes;
  logic [3:0]           aluFlags;

  cpuBusIf    busIf ();
  writebackIf wbIf ();

  instrSequencer #(
    .resetVector(resetVector),
    .ioBase     (ioBase)
  ) sequencer (
    .clk     (clk),
    .reset   (reset),
    .bus     (busIf.controller),
    .wb      (wbIf.controller),
    .aluOp   (aluOp),
    .aluB    (aluB),
    .aluRes  (aluRes),
    .aluFlags(aluFlags),
    .trap    (trap)
  );

  aluUnit alu (
    .op      (aluOp),
    .a       (aluA),
    .b       (aluB),
    .flagsIn (wbIf.fData), // Carry in for ADC, SBC and INC
    .res     (aluRes),
    .flagsOut(aluFlags)
  );

  registerFile regs (
    .clk  (clk),
    .reset(reset),
    .wb   (wbIf.worker),
    .aData(aluA)
  );

  wbMaster master (
    .clk   (clk),
    .reset (reset),
    .bus   (busIf.worker),
    .wbAdr (wbAdr),
    .wbDatO(wbDatO),
    .wbDatI(wbDatI),
    .wbWe  (wbWe),
    .wbCyc (wbCyc),
    .wbStb (wbStb),
    .wbAck (wbAck)
  );

endmodule

`default_nettype wire

// ==== verif/tbChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbChecker import sm83Pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [addrWidth-1:0] wbAdr,
  input  logic [dataWidth-1:0] wbDatO,
  input  logic                 wbWe,
  input  logic                 wbCyc,
  input  logic                 wbStb,
  input  logic                 wbAck,
  input  logic                 trap,
  input  logic [7:0]           memImage [0:65535],
  output logic                 done,
  output int                   errors
);

  localparam int quietCycles = 20; // Watched after trap

  logic [7:0]  mdl [0:65535]; // Model copy of memory
  logic [7:0]  regs [0:7];    // Index 6 unused
  logic        fz, fc;
  logic [15:0] mpc;
  logic [24:0] expQ [$];      // {we, adr, data}
  logic        modelReady;
  int          expWrites, obsWrites, accessCount;
  int          errReset, errReads, errWrites, errTrap;
  int          testsPassed, testsFailed;
  int          i;

  task automatic readNext(output logic [7:0] b);
    expQ.push_back({1'b0, mpc, 8'h00});
    b = mdl[mpc];
    mpc = mpc + 16'd1;
  endtask

  task automatic aluStep(input logic [2:0] op, input logic [7:0] b);
    int         a, bi, cin, full;
    logic [7:0] res;
    a = int'(regs[7]);
    bi = int'(b);
    cin = ((op == 3'd1 || op == 3'd3) && fc) ? 1 : 0;
    fc = 1'b0;
    full = 0;
    case (op)
      3'd0, 3'd1:
      begin
        full = a + bi + cin;
        fc = (full > 255);
      end
      3'd2, 3'd3, 3'd7:
      begin
        full = a - bi - cin;
        fc = (full < 0);
      end
      3'd4:
        full = a & bi;
      3'd5:
        full = a ^ bi;
      default:
        full = a | bi;
    endcase
    res = 8'(full);
    fz = (res == 8'h00);
    if (op != 3'd7)
      regs[7] = res; // CP keeps A
  endtask

  task automatic runModel();
    logic [7:0]  op, arg, res;
    logic [2:0]  y, z;
    logic [15:0] io;
    logic        take, stop;
    int          k, steps;
    mpc = 16'h0000;
    stop = 1'b0;
    steps = 0;
    fz = 1'b0;
    fc = 1'b0;
    for (k = 0; k < 8; k++)
      regs[k] = 8'h00;
    while (!stop && steps < 100000)
    begin
      readNext(op);
      y = op[5:3];
      z = op[2:0];
      if (op[7:6] == 2'd0 && z == 3'd6 && y != 3'd6)
      begin
        readNext(arg); // LD r, d8
        regs[y] = arg;
      end
      else if (op[7:6] == 2'd0 && z == 3'd4 && y != 3'd6)
      begin
        res = regs[y] + 8'd1; // C unchanged
        fz = (res == 8'h00);
        regs[y] = res;
      end
      else if (op == 8'h20 || op == 8'h28 || op == 8'h30 || op == 8'h38)
      begin
        readNext(arg);
        case (y[1:0])
          2'd0: take = !fz;
          2'd1: take = fz;
          2'd2: take = !fc;
          default: take = fc;
        endcase
        if (take)
          mpc = mpc + {{8{arg[7]}}, arg};
      end
      else if (op[7:6] == 2'd2 && z != 3'd6)
        aluStep(y, regs[z]);
      else if (op == 8'hE0 || op == 8'hF0)
      begin
        readNext(arg);
        io = ioPageBase + {8'h00, arg};
        if (op == 8'hE0)
        begin
          expQ.push_back({1'b1, io, regs[7]});
          mdl[io] = regs[7];
          expWrites++;
        end
        else
        begin
          expQ.push_back({1'b0, io, 8'h00});
          regs[7] = mdl[io];
        end
      end
      else if (op != 8'h00)
        stop = 1'b1; // Undefined opcode
      steps++;
    end
  endtask

  task automatic checkAccess();
    logic [24:0] exp;
    if (accessCount == 0 && (wbWe !== 1'b0 || wbAdr !== 16'h0000))
    begin
      errReset++;
      $display("Error: wbAdr expected 0000 got %h on the first access, wbWe %h", wbAdr, wbWe);
    end
    if (trap)
    begin
      errTrap++;
      $display("Bus access to %h completed while trap is high", wbAdr);
    end
    else if (expQ.size() == 0)
    begin
      errReads++;
      $display("Bus access to %h that the model does not predict", wbAdr);
    end
    else
    begin
      exp = expQ.pop_front();
      if (wbWe !== exp[24])
      begin
        errReads++;
        $display("Error: wbWe expected %h got %h at wbAdr %h", exp[24], wbWe, wbAdr);
      end
      else if (wbAdr !== exp[23:8])
      begin
        if (wbWe)
          errWrites++;
        else
          errReads++;
        $display("Error: wbAdr expected %h got %h", exp[23:8], wbAdr);
      end
      else if (wbWe && wbDatO !== exp[7:0])
      begin
        errWrites++;
        $display("Error: wbDatO expected %h got %h at %h", exp[7:0], wbDatO, wbAdr);
      end
    end
    if (wbWe)
      obsWrites++;
    accessCount++;
  endtask

  task automatic reportTest(input string name, input int errs);
    if (errs == 0)
    begin
      testsPassed++;
      $display("%s: pass", name);
    end
    else
    begin
      testsFailed++;
      $display("%s: fail with %0d errors", name, errs);
    end
  endtask

  always @(negedge clk)
  begin
    if (!reset && modelReady && wbCyc && wbStb && wbAck)
      checkAccess();
  end

  initial
  begin
    done = 1'b0;
    errors = 0;
    modelReady = 1'b0;
    @(negedge reset);
    for (i = 0; i < 65536; i++)
      mdl[i] = memImage[i];
    runModel();
    modelReady = 1'b1;
    @(negedge clk);
    if (wbCyc !== 1'b0 || wbStb !== 1'b0 || wbWe !== 1'b0 || trap !== 1'b0)
    begin
      errReset++;
      $display("Error: wbCyc %h wbStb %h wbWe %h trap %h after reset, expected all 0",
               wbCyc, wbStb, wbWe, trap);
    end
    wait (accessCount > 0);
    reportTest("reset state", errReset);
    wait (trap === 1'b1);
    @(negedge clk);
    if (expQ.size() != 0)
    begin
      errReads++;
      $display("Trap raised with %0d model accesses still pending", expQ.size());
    end
    reportTest("fetch and read order", errReads);
    if (obsWrites != expWrites)
    begin
      errWrites++;
      $display("Saw %0d writes but the model predicts %0d", obsWrites, expWrites);
    end
    reportTest("write address and data", errWrites);
    repeat (quietCycles)
    begin
      @(negedge clk);
      if (trap !== 1'b1)
      begin
        errTrap++;
        $display("Error: trap expected 1 got %h", trap);
      end
      if (wbCyc !== 1'b0)
      begin
        errTrap++;
        $display("Bus cycle to %h started after trap", wbAdr);
      end
    end
    reportTest("trap hold", errTrap);
    errors = errReset + errReads + errWrites + errTrap;
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d accesses, %0d writes",
             testsPassed + testsFailed, testsPassed, testsFailed, accessCount, obsWrites);
    done = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/tbTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbTop import sm83Pkg::*; ();

  localparam int numInstr  = 150;
  localparam int clkPeriod = 100;
  localparam int stimDelay = 10; // After the rising edge

  logic                 clk;
  logic                 reset;
  logic [addrWidth-1:0] wbAdr;
  logic [dataWidth-1:0] wbDatO;
  logic [dataWidth-1:0] wbDatI;
  logic                 wbWe;
  logic                 wbCyc;
  logic                 wbStb;
  logic                 wbAck;
  logic                 trap;

  logic [7:0]           mem [0:65535];
  logic [31:0]          lcgState;
  logic [addrWidth-1:0] progAdr;
  int                   instrCount;
  int                   waitLeft;
  int                   timeLimit;
  logic                 progReady;
  logic                 checkDone;
  int                   checkErrors;

  sm83Core dut (
    .clk   (clk),
    .reset (reset),
    .wbAdr (wbAdr),
    .wbDatO(wbDatO),
    .wbDatI(wbDatI),
    .wbWe  (wbWe),
    .wbCyc (wbCyc),
    .wbStb (wbStb),
    .wbAck (wbAck),
    .trap  (trap)
  );

  tbChecker busCheck (
    .clk     (clk),
    .reset   (reset),
    .wbAdr   (wbAdr),
    .wbDatO  (wbDatO),
    .wbWe    (wbWe),
    .wbCyc   (wbCyc),
    .wbStb   (wbStb),
    .wbAck   (wbAck),
    .trap    (trap),
    .memImage(mem),
    .done    (checkDone),
    .errors  (checkErrors)
  );

  initial
    clk = 1'b0;

  always #(clkPeriod / 2) clk = ~clk;

  function automatic logic [7:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[23:16];
  endfunction

  function automatic logic [2:0] randReg();
    logic [7:0] v;
    v = nextRand() % 8'd7;
    return (v[2:0] == 3'd6) ? 3'd7 : v[2:0]; // Skip the [HL] slot
  endfunction

  // One-byte INC r or ALU op on A
  function automatic logic [7:0] randSingle();
    logic [7:0] v;
    v = nextRand();
    if (v[7])
      return {2'b10, v[5:3], randReg()};
    return {2'b00, randReg(), 3'd4};
  endfunction

  task automatic putByte(input logic [7:0] b);
    mem[progAdr] = b;
    progAdr = progAdr + 16'd1;
  endtask

  task automatic buildProgram();
    logic [7:0] sel;
    logic [7:0] v;
    int         i;
    for (i = 0; i < 65536; i++)
      mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'hA5;
    for (i = 0; i < 256; i++)
      mem[ioPageBase + 16'(i)] = nextRand();
    progAdr = 16'h0000;
    instrCount = 0;
    while (instrCount < numInstr)
    begin
      sel = nextRand() % 8'd8;
      case (sel)
        8'd0:
          putByte(8'h00);
        8'd1, 8'd2:
        begin
          putByte({2'b00, randReg(), 3'd6}); // LD r, d8
          putByte(nextRand());
        end
        8'd3, 8'd4:
          putByte(randSingle());
        8'd5:
        begin
          v = nextRand();
          putByte({3'b001, v[1:0], 3'b000}); // JR cc
          putByte({6'd0, v[3:2]});
          for (i = 0; i < int'(v[3:2]); i++)
          begin
            putByte(randSingle()); // Bytes a taken branch skips
            instrCount++;
          end
        end
        default:
        begin
          v = nextRand();
          putByte(sel[0] ? 8'hE0 : 8'hF0);
          putByte({3'b000, v[4:0]}); // Small range so loads hit stores
        end
      endcase
      instrCount++;
    end
    putByte(8'hD3);
  endtask

  // Wishbone slave memory with 0 to 3 wait states
  always @(posedge clk)
  begin
    #stimDelay;
    if (reset || wbAck)
      wbAck = 1'b0;
    else if (wbCyc && wbStb)
    begin
      if (waitLeft > 0)
        waitLeft--;
      else
      begin
        if (wbWe)
          mem[wbAdr] = wbDatO;
        else
          wbDatI = mem[wbAdr];
        wbAck = 1'b1;
        waitLeft = int'(nextRand() % 8'd4);
      end
    end
  end

  initial
  begin
    wait (progReady === 1'b1);
    #(timeLimit);
    $display("Timeout after %0d ns before the checks ended", timeLimit);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    reset     = 1'b1;
    wbAck     = 1'b0;
    wbDatI    = 8'h00;
    waitLeft  = 0;
    lcgState  = 32'd65;
    progReady = 1'b0;
    buildProgram();
    timeLimit = (instrCount * 4 * 5 + 200) * clkPeriod;
    progReady = 1'b1;
    $display("Program of %0d instructions in %0d bytes", instrCount, progAdr);
    repeat (5) @(posedge clk);
    #stimDelay;
    reset = 1'b0;
    wait (checkDone === 1'b1);
    if (checkErrors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/sm83Pkg.sv
src/cpuBusIf.sv
src/writebackIf.sv
src/aluUnit.sv
src/registerFile.sv
src/wbMaster.sv
src/instrSequencer.sv
src/sm83Core.sv
verif/tbChecker.sv
verif/tbTop.sv

// ==== Makefile ====
# Verilator build and run for the SM83 style core

VERILATOR ?= verilator
TOP       ?= tbTop
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
